// File: vlog.f
source/mbu_pkg.sv
source/mbu_io_decode.sv
source/mbu_cu_decode.sv
source/mbu_port_arbiter.sv
source/mbu_bank_regs.sv
source/mbu_top.sv
verification/mbu_checker.sv
verification/mbu_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the memory bank unit testbench with Verilator and runs it
# The result is taken from the pass line in sim.log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
   --timescale 1ns/1ps \
   --top-module mbu_tb \
   -f vlog.f \
   -o mbu_sim

./obj_dir/mbu_sim | tee sim.log

if grep -q "^Regression passed$" sim.log; then
   echo "Simulation result: PASS"
   exit 0
else
   echo "Simulation result: FAIL"
   exit 1
fi

// File: verification/mbu_tb.sv
// Testbench top for the memory bank unit
// Inputs change on the falling edge and the checker samples on the rising edge
// I/O strobes are always followed by an idle cycle, as the bus protocol demands
// The cycle after a strobe carries no write_mbp so a parked OUT drains in time
`timescale 1ns/1ps

module mbu_tb;

   localparam logic [7:0] IO_BASE = 8'h08;
   localparam int RESET_CYCLES    = 16;
   localparam int DIRECTED_CYCLES = 120;
   localparam int RAND_CYCLES     = 2000;
   localparam int LIMIT_CYCLES    = RESET_CYCLES + DIRECTED_CYCLES + RAND_CYCLES + 200;

   logic clk;
   logic rst_n;
   logic [4:0] raddr;
   logic [4:0] waddr;
   logic t34;
   logic nir_idx;
   logic [2:0] ir;
   logic [7:0] ibus_in;
   logic [7:0] ibus_out;
   logic ibus_oe;
   logic [7:0] ab;
   logic nsysdev;
   logic nr;
   logic nw;
   logic [7:0] db_in;
   logic [7:0] db_out;
   logic db_oe;
   logic fpram_rom_n;
   logic [7:0] aext;
   logic nwar;
   logic [2:0] test_id;
   logic run_end;
   logic [31:0] rnd;
   logic after_strobe;
   int chk_total;
   int err_total;

   mbu_top #(.IO_BASE(IO_BASE)) u_mbu_top (
      .clk(clk), .rst_n(rst_n), .raddr(raddr), .waddr(waddr), .t34(t34),
      .nir_idx(nir_idx), .ir(ir), .ibus_in(ibus_in), .ibus_out(ibus_out),
      .ibus_oe(ibus_oe), .ab(ab), .nsysdev(nsysdev), .nr(nr), .nw(nw),
      .db_in(db_in), .db_out(db_out), .db_oe(db_oe), .fpram_rom_n(fpram_rom_n),
      .aext(aext), .nwar(nwar)
   );

   mbu_checker #(.IO_BASE(IO_BASE)) u_checker (
      .clk(clk), .rst_n(rst_n), .raddr(raddr), .waddr(waddr), .t34(t34),
      .nir_idx(nir_idx), .ir(ir), .ibus_in(ibus_in), .ibus_out(ibus_out),
      .ibus_oe(ibus_oe), .ab(ab), .nsysdev(nsysdev), .nr(nr), .nw(nw),
      .db_in(db_in), .db_out(db_out), .db_oe(db_oe), .fpram_rom_n(fpram_rom_n),
      .aext(aext), .nwar(nwar), .test_id(test_id), .run_end(run_end),
      .chk_total(chk_total), .err_total(err_total)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // Ends a run that stalls well past the planned number of cycles
   initial begin
      repeat (LIMIT_CYCLES) @(posedge clk);
      $display("Timeout: the run did not reach its end within %0d cycles", LIMIT_CYCLES);
      $display("Regression failed");
      $finish;
   end

   ////////////////////
   // Stimulus tasks
   ////////////////////

   // Bus idle with no microcode request, leaves fpram_rom_n and rst_n alone
   task automatic quiet_inputs();
      raddr   = 5'b00000;
      waddr   = 5'b00000;
      t34     = 1'b0;
      nir_idx = 1'b1;
      ir      = 3'd0;
      ibus_in = 8'h00;
      ab      = 8'h00;
      nsysdev = 1'b1;
      nr      = 1'b1;
      nw      = 1'b1;
      db_in   = 8'h00;
   endtask

   task automatic idle_cycles(input int n);
      repeat (n) begin
         @(negedge clk);
         quiet_inputs();
      end
   endtask

   // One strobe cycle and the idle cycle after it
   task automatic io_access(input logic [7:0] addr, input logic wr, input logic [7:0] data,
                            input logic sysdev_n);
      @(negedge clk);
      quiet_inputs();
      ab      = addr;
      nsysdev = sysdev_n;
      db_in   = data;
      if (wr) begin
         nw = 1'b0;
      end else begin
         nr = 1'b0;
      end
      idle_cycles(1);
   endtask

   task automatic cu_access(input logic [4:0] ra, input logic [4:0] wa, input logic t,
                            input logic nidx, input logic [2:0] irv, input logic [7:0] bus);
      @(negedge clk);
      quiet_inputs();
      raddr   = ra;
      waddr   = wa;
      t34     = t;
      nir_idx = nidx;
      ir      = irv;
      ibus_in = bus;
   endtask

   // One random cycle, an I/O strobe at most every other cycle
   task automatic random_cycle();
      @(negedge clk);
      quiet_inputs();
      rnd = $urandom;
      raddr = (rnd[1:0] == 2'd0) ? {4'b0110, rnd[2]} : rnd[7:3];
      case (rnd[9:8])
         2'd0:    waddr = {4'b0110, rnd[10]};
         2'd1:    waddr = {3'b001, rnd[12:11]};
         default: waddr = rnd[17:13];
      endcase
      t34         = rnd[18];
      nir_idx     = rnd[19];
      ir          = rnd[22:20];
      ibus_in     = rnd[30:23];
      fpram_rom_n = rnd[31];
      rnd = $urandom;
      if (after_strobe) begin
         after_strobe = 1'b0;
         if (waddr[4:1] == 4'b0110) begin
            waddr = 5'b00000;
         end
      end else if (rnd[1:0] == 2'd0) begin
         ab      = rnd[4] ? {IO_BASE[7:3], rnd[7:5]} : rnd[15:8];
         nsysdev = (rnd[18:16] == 3'd0);
         db_in   = rnd[27:20];
         if (rnd[19]) begin
            nw = 1'b0;
         end else begin
            nr = 1'b0;
         end
         after_strobe = 1'b1;
      end
   endtask

   ////////////////////
   // Test sequence
   ////////////////////

   initial begin
      rnd = $urandom(55);
      quiet_inputs();
      rst_n = 1'b0;
      fpram_rom_n = 1'b1;
      test_id = 3'd1;
      run_end = 1'b0;
      after_strobe = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
      // Disabled unit shows only the RAM/ROM bit, even with an indexed select
      for (int i = 0; i < 6; i++) begin
         @(negedge clk);
         quiet_inputs();
         fpram_rom_n = ~fpram_rom_n;
         if (i[0]) begin
            waddr = {3'b001, i[2:1]};
         end
      end
      test_id = 3'd2;
      for (int i = 0; i < 8; i++) begin
         io_access(IO_BASE + {5'd0, i[2:0]}, 1'b1, 8'h17 ^ {i[2:0], 5'b10101}, 1'b0);
      end
      for (int i = 0; i < 8; i++) begin
         io_access(IO_BASE + {5'd0, i[2:0]}, 1'b0, 8'h00, 1'b0);
      end
      // Outside the window or outside device space nothing may change
      io_access(IO_BASE + 8'h08, 1'b1, 8'hEE, 1'b0);
      io_access(IO_BASE - 8'h01, 1'b1, 8'hDD, 1'b0);
      io_access(IO_BASE + 8'h02, 1'b1, 8'hCC, 1'b1);
      for (int i = 0; i < 8; i++) begin
         io_access(IO_BASE + {5'd0, i[2:0]}, 1'b0, 8'h00, 1'b0);
      end
      test_id = 3'd3;
      cu_access(5'b00000, 5'b01100, 1'b0, 1'b1, 3'd0, 8'hC3);
      cu_access(5'b01100, 5'b00000, 1'b0, 1'b1, 3'd0, 8'h00);
      cu_access(5'b01101, 5'b00000, 1'b1, 1'b1, 3'd0, 8'h00);
      cu_access(5'b00000, 5'b01101, 1'b0, 1'b1, 3'd0, 8'h3C);
      cu_access(5'b01101, 5'b00000, 1'b0, 1'b1, 3'd0, 8'h00);
      // Read and write of MB0 in one microinstruction reads the old value
      cu_access(5'b01100, 5'b01100, 1'b0, 1'b1, 3'd0, 8'h96);
      cu_access(5'b01100, 5'b00000, 1'b0, 1'b1, 3'd0, 8'h00);
      idle_cycles(2);
      test_id = 3'd4;
      for (int i = 0; i < 8; i++) begin
         cu_access(5'b00000, {3'b001, ~i[1:0]}, 1'b0, 1'b0, i[2:0], 8'h00);
      end
      for (int i = 0; i < 4; i++) begin
         cu_access(5'b00000, {3'b001, i[1:0]}, 1'b0, 1'b1, 3'd7, 8'h00);
      end
      idle_cycles(2);
      test_id = 3'd5;
      // OUT meets write_mbp and drains on the idle edge after it
      cu_access(5'b00000, 5'b01100, 1'b0, 1'b1, 3'd0, 8'hA5);
      ab = IO_BASE + 8'h05;
      nsysdev = 1'b0;
      nw = 1'b0;
      db_in = 8'h5A;
      idle_cycles(1);
      io_access(IO_BASE + 8'h05, 1'b0, 8'h00, 1'b0);
      // A second write_mbp holds the parked OUT for one more cycle
      cu_access(5'b00000, 5'b01101, 1'b0, 1'b1, 3'd0, 8'h11);
      ab = IO_BASE + 8'h06;
      nsysdev = 1'b0;
      nw = 1'b0;
      db_in = 8'hC7;
      cu_access(5'b00000, 5'b01100, 1'b0, 1'b1, 3'd0, 8'h22);
      io_access(IO_BASE + 8'h06, 1'b0, 8'h00, 1'b0);
      io_access(IO_BASE + 8'h06, 1'b0, 8'h00, 1'b0);
      cu_access(5'b01100, 5'b00000, 1'b0, 1'b1, 3'd0, 8'h00);
      idle_cycles(2);
      test_id = 3'd6;
      repeat (RAND_CYCLES) random_cycle();
      idle_cycles(3);
      run_end = 1'b1;
      @(posedge clk);
      #1;
      if (err_total == 0 && chk_total > 0) begin
         $display("Regression passed");
      end else begin
         if (chk_total == 0) begin
            $display("No output was ever checked");
         end
         $display("Regression failed");
      end
      $finish;
   end

endmodule

// File: verification/mbu_checker.sv
// Cycle checker for the memory bank unit
// Keeps its own shadow of the bank registers, the enable flag and the pending I/O write
// Inputs are sampled on the rising edge, where the falling-edge stimulus is stable
// Registered outputs are compared with the values predicted at the previous edge
`timescale 1ns/1ps

module mbu_checker #(
   parameter logic [7:0] IO_BASE = 8'h08
) (
   input  logic               clk,
   input  logic               rst_n,
   input  logic [4:0]         raddr,
   input  logic [4:0]         waddr,
   input  logic               t34,
   input  logic               nir_idx,
   input  mbu_pkg::mbu_idx_t  ir,
   input  mbu_pkg::mbu_byte_t ibus_in,
   input  mbu_pkg::mbu_byte_t ibus_out,
   input  logic               ibus_oe,
   input  mbu_pkg::mbu_byte_t ab,
   input  logic               nsysdev,
   input  logic               nr,
   input  logic               nw,
   input  mbu_pkg::mbu_byte_t db_in,
   input  mbu_pkg::mbu_byte_t db_out,
   input  logic               db_oe,
   input  logic               fpram_rom_n,
   input  mbu_pkg::mbu_byte_t aext,
   input  logic               nwar,
   input  logic [2:0]         test_id,
   input  logic               run_end,
   output int                 chk_total,
   output int                 err_total
);

   // All DUT inputs of one cycle, 43 bits
   typedef struct packed {
      logic [4:0] raddr;
      logic [4:0] waddr;
      logic       t34;
      logic       nir_idx;
      logic [2:0] ir;
      logic [7:0] ibus_in;
      logic [7:0] ab;
      logic       nsysdev;
      logic       nr;
      logic       nw;
      logic [7:0] db_in;
      logic       fpram_rom_n;
   } in_smp_t;

   // Registered outputs expected after one edge
   typedef struct packed {
      logic [7:0] aext;
      logic [7:0] ibus_out;
      logic       ibus_oe;
      logic [7:0] db_out;
      logic       db_oe;
   } exp_out_t;

   // Parked I/O write
   typedef struct packed {
      logic       valid;
      logic [2:0] idx;
      logic [7:0] data;
   } pend_t;

   logic [7:0] sh_regs [8];
   logic       sh_en;
   pend_t      pend;
   in_smp_t    smp;
   exp_out_t   exp_q;
   logic       model_live = 1'b0;
   logic       run_done = 1'b0;
   logic [2:0] cur_test = 3'd1;
   int         test_checks = 0;
   int         test_errs = 0;

   initial chk_total = 0;
   initial err_total = 0;

   ////////////////////
   // Reference model
   ////////////////////

   // Strobe-independent part of the I/O address match
   function automatic logic in_window(input in_smp_t s);
      return !s.nsysdev && (s.ab[7:3] == IO_BASE[7:3]);
   endfunction

   // Outputs after the edge, from the register values before that edge's write
   function automatic exp_out_t expected_outputs(input in_smp_t s);
      exp_out_t   e;
      logic       io_rd;
      logic       rd_mbp;
      logic       indexed;
      logic [2:0] sel;
      logic [7:0] val;
      io_rd   = in_window(s) && !s.nr;
      rd_mbp  = (s.raddr[4:1] == 4'b0110) && !s.t34;
      indexed = (s.waddr[4:2] == 3'b001);
      // read_mbp first, then IN, then an indexed access, else MB0
      if (rd_mbp) begin
         sel = 3'd0;
      end else if (io_rd) begin
         sel = s.ab[2:0];
      end else if (indexed) begin
         sel = s.nir_idx ? {1'b0, s.waddr[1:0]} : s.ir;
      end else begin
         sel = 3'd0;
      end
      // The enabling access itself already reads a register
      if (sh_en || (in_window(s) && (!s.nr || !s.nw))) begin
         val = sh_regs[sel];
      end else begin
         val = {s.fpram_rom_n, 7'd0};
      end
      e.aext     = val;
      e.ibus_oe  = rd_mbp;
      e.ibus_out = rd_mbp ? val : 8'h00;
      e.db_oe    = io_rd && !rd_mbp;
      e.db_out   = e.db_oe ? val : 8'h00;
      return e;
   endfunction

   // Control-unit writes go first, a colliding OUT waits for a free edge
   task automatic advance_model(input in_smp_t s);
      logic io_wr;
      logic cu_wr;
      io_wr = in_window(s) && !s.nw;
      cu_wr = (s.waddr[4:1] == 4'b0110);
      if (in_window(s) && (!s.nr || !s.nw)) begin
         sh_en = 1'b1;
      end
      if (cu_wr) begin
         sh_regs[0] = s.ibus_in;
         if (io_wr) begin
            pend = {1'b1, s.ab[2:0], s.db_in};
         end
      end else if (pend.valid) begin
         sh_regs[pend.idx] = pend.data;
         pend = {io_wr, s.ab[2:0], s.db_in};
      end else if (io_wr) begin
         sh_regs[s.ab[2:0]] = s.db_in;
      end
   endtask

   task automatic reset_model(input in_smp_t s);
      for (int i = 0; i < 8; i++) begin
         sh_regs[i] = 8'h00;
      end
      sh_en = 1'b0;
      pend  = '0;
      exp_q = '0;
      exp_q.aext = {s.fpram_rom_n, 7'd0};
   endtask

   ////////////////////
   // Compare and report
   ////////////////////

   task automatic check_value(input string sig, input logic [7:0] exp_v,
                              input logic [7:0] act_v);
      test_checks++;
      chk_total++;
      if (act_v !== exp_v) begin
         test_errs++;
         err_total++;
         $display("FAIL t=%0t %s expected %0h got %0h", $time, sig, exp_v, act_v);
      end
   endtask

   function automatic string test_name(input logic [2:0] id);
      case (id)
         3'd1:    return "power_on_default";
         3'd2:    return "io_write_read";
         3'd3:    return "mbp_write_read";
         3'd4:    return "indexed_select";
         3'd5:    return "write_collision";
         3'd6:    return "random_mix";
         default: return "unknown";
      endcase
   endfunction

   task automatic report_test();
      $display("test %0d %s: %0d checks, %0d errors", cur_test, test_name(cur_test),
               test_checks, test_errs);
      test_checks = 0;
      test_errs   = 0;
   endtask

   always @(posedge clk) begin
      smp = {raddr, waddr, t34, nir_idx, ir, ibus_in, ab, nsysdev, nr, nw, db_in, fpram_rom_n};
      if (model_live) begin
         check_value("aext", exp_q.aext, aext);
         check_value("ibus_out", exp_q.ibus_out, ibus_out);
         check_value("ibus_oe", {7'd0, exp_q.ibus_oe}, {7'd0, ibus_oe});
         check_value("db_out", exp_q.db_out, db_out);
         check_value("db_oe", {7'd0, exp_q.db_oe}, {7'd0, db_oe});
         // nwar is combinational and follows the inputs of this cycle
         check_value("nwar", {7'd0, !(smp.waddr[4:2] == 3'b001)}, {7'd0, nwar});
      end
      if (!rst_n) begin
         reset_model(smp);
         model_live = 1'b1;
      end else begin
         exp_q = expected_outputs(smp);
         advance_model(smp);
      end
      if (test_id != cur_test) begin
         report_test();
         cur_test = test_id;
      end
      if (run_end && !run_done) begin
         report_test();
         $display("Totals: %0d checks, %0d errors", chk_total, err_total);
         run_done = 1'b1;
      end
   end

endmodule

// File: source/mbu_top.sv
// Top level of the memory bank unit
// Tri-state buses are split into separate input, output and output-enable ports
// Reads appear one cycle after the selecting inputs, writes land on the ending edge
// IO_BASE sets the first of the eight I/O addresses, a multiple of 8 below 8'h80
`timescale 1ns/1ps

module mbu_top #(
   parameter logic [7:0] IO_BASE = 8'h08
) (
   input  logic               clk,
   input  logic               rst_n,
   // Control unit side
   input  logic [4:0]         raddr,
   input  logic [4:0]         waddr,
   input  logic               t34,
   input  logic               nir_idx,
   input  mbu_pkg::mbu_idx_t  ir,
   input  mbu_pkg::mbu_byte_t ibus_in,
   output mbu_pkg::mbu_byte_t ibus_out,
   output logic               ibus_oe,
   // System bus side
   input  mbu_pkg::mbu_byte_t ab,
   input  logic               nsysdev,
   input  logic               nr,
   input  logic               nw,
   input  mbu_pkg::mbu_byte_t db_in,
   output mbu_pkg::mbu_byte_t db_out,
   output logic               db_oe,
   // Front panel and address extension
   input  logic               fpram_rom_n,
   output mbu_pkg::mbu_byte_t aext,
   output logic               nwar
);

   ////////////////////
   // Internal wiring
   ////////////////////

   mbu_pkg::mbu_io_req_t io_req;
   logic                 io_hit;
   mbu_pkg::mbu_wr_req_t cu_wr;
   mbu_pkg::mbu_rd_sel_t cu_rd;
   mbu_pkg::mbu_wr_req_t wr_grant;
   mbu_pkg::mbu_idx_t    rd_idx;
   logic                 rd_mbp;
   logic                 rd_io;

   // I/O port decode
   mbu_io_decode #(
      .IO_BASE (IO_BASE)
   ) u_io_decode (
      .clk     (clk),
      .rst_n   (rst_n),
      .ab      (ab),
      .nsysdev (nsysdev),
      .nr      (nr),
      .nw      (nw),
      .db_in   (db_in),
      .io_req  (io_req),
      .io_hit  (io_hit)
   );

   // Microcode address decode
   mbu_cu_decode u_cu_decode (
      .raddr   (raddr),
      .waddr   (waddr),
      .t34     (t34),
      .nir_idx (nir_idx),
      .ir      (ir),
      .ibus_in (ibus_in),
      .cu_wr   (cu_wr),
      .cu_rd   (cu_rd),
      .nwar    (nwar)
   );

   // Shares the single write port and read select
   mbu_port_arbiter u_port_arbiter (
      .clk      (clk),
      .rst_n    (rst_n),
      .cu_wr    (cu_wr),
      .cu_rd    (cu_rd),
      .io_req   (io_req),
      .wr_grant (wr_grant),
      .rd_idx   (rd_idx),
      .rd_mbp   (rd_mbp),
      .rd_io    (rd_io)
   );

   // Bank registers and registered outputs
   mbu_bank_regs u_bank_regs (
      .clk         (clk),
      .rst_n       (rst_n),
      .wr_grant    (wr_grant),
      .rd_idx      (rd_idx),
      .rd_mbp      (rd_mbp),
      .rd_io       (rd_io),
      .io_hit      (io_hit),
      .fpram_rom_n (fpram_rom_n),
      .aext        (aext),
      .ibus_out    (ibus_out),
      .ibus_oe     (ibus_oe),
      .db_out      (db_out),
      .db_oe       (db_oe)
   );

endmodule

// File: source/mbu_bank_regs.sv
// Register file of the eight bank registers plus the unit enable flag
// All outputs are registered and show register contents from before the same edge's write
// Until the first I/O access aext shows fpram_rom_n in bit 7 and zeros below
`timescale 1ns/1ps

module mbu_bank_regs (
   input  logic                 clk,
   input  logic                 rst_n,
   input  mbu_pkg::mbu_wr_req_t wr_grant,
   input  mbu_pkg::mbu_idx_t    rd_idx,
   input  logic                 rd_mbp,
   input  logic                 rd_io,
   input  logic                 io_hit,
   input  logic                 fpram_rom_n,
   output mbu_pkg::mbu_byte_t   aext,
   output mbu_pkg::mbu_byte_t   ibus_out,
   output logic                 ibus_oe,
   output mbu_pkg::mbu_byte_t   db_out,
   output logic                 db_oe
);

   ////////////////////
   // Storage
   ////////////////////

   mbu_pkg::mbu_byte_t regs [mbu_pkg::MBU_NREGS];
   logic               en_q;
   logic               en_d;
   mbu_pkg::mbu_byte_t sel_val;

   // The enabling access already sees its own register
   // This lets a first IN return data instead of the default
   assign en_d = en_q || io_hit;

   // Disabled units drive only the front panel RAM/ROM bit
   assign sel_val = en_d ? regs[rd_idx] : {fpram_rom_n, 7'b000_0000};

   // All eight registers clear on reset
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         for (int i = 0; i < mbu_pkg::MBU_NREGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_grant.valid) begin
         regs[wr_grant.idx] <= wr_grant.data;
      end
   end

   // Once set, only reset clears the enable
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         en_q <= 1'b0;
      end else begin
         en_q <= en_d;
      end
   end

   ////////////////////
   // Output registers
   ////////////////////

   // aext is always driven, the two bus copies only while selected
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         aext     <= {fpram_rom_n, 7'b000_0000};
         ibus_out <= '0;
         ibus_oe  <= 1'b0;
         db_out   <= '0;
         db_oe    <= 1'b0;
      end else begin
         aext     <= sel_val;
         ibus_out <= rd_mbp ? sel_val : '0;
         ibus_oe  <= rd_mbp;
         db_out   <= rd_io ? sel_val : '0;
         db_oe    <= rd_io;
      end
   end

   // The internal bus and the data bus are never driven from the same read
   a_one_bus_drive : assert property (
      @(posedge clk) disable iff (!rst_n)
      !(ibus_oe && db_oe)
   );

endmodule

// File: source/mbu_port_arbiter.sv
// Fixed-priority arbiter between the control unit and the I/O port
// The control unit always wins the write port, a losing I/O write waits in one slot
// The slot drains on the first edge without a control-unit write
// Reads are not deferred, an I/O read that loses to read_mbp gets no data bus cycle
`timescale 1ns/1ps

module mbu_port_arbiter (
   input  logic                 clk,
   input  logic                 rst_n,
   input  mbu_pkg::mbu_wr_req_t cu_wr,
   input  mbu_pkg::mbu_rd_sel_t cu_rd,
   input  mbu_pkg::mbu_io_req_t io_req,
   output mbu_pkg::mbu_wr_req_t wr_grant,
   output mbu_pkg::mbu_idx_t    rd_idx,
   output logic                 rd_mbp,
   output logic                 rd_io
);

   mbu_pkg::mbu_wr_req_t io_wr;
   mbu_pkg::mbu_wr_req_t pend_q;
   mbu_pkg::mbu_wr_req_t pend_d;

   // The I/O write seen as a plain register file write
   assign io_wr = '{valid: io_req.wr, idx: io_req.idx, data: io_req.data};

   ////////////////////
   // Write port
   ////////////////////

   always_comb begin
      wr_grant = '0;
      pend_d   = pend_q;
      if (cu_wr.valid) begin
         wr_grant = cu_wr;
         // Park a colliding I/O write for the next free edge
         if (io_wr.valid) begin
            pend_d = io_wr;
         end
      end else if (pend_q.valid) begin
         // The parked write drains first and a fresh I/O write takes its place
         wr_grant = pend_q;
         pend_d   = io_wr;
      end else begin
         wr_grant = io_wr;
      end
   end

   // Reset only empties the slot
   always_ff @(posedge clk) begin
      if (!rst_n) begin
         pend_q.valid <= 1'b0;
      end else begin
         pend_q <= pend_d;
      end
   end

   ////////////////////
   // Read select
   ////////////////////

   // Order is read_mbp, then IN, then an indexed access, then MB0
   always_comb begin
      rd_mbp = cu_rd.valid && cu_rd.mbp;
      rd_io  = io_req.rd && !rd_mbp;
      if (rd_mbp) begin
         rd_idx = '0;
      end else if (io_req.rd) begin
         rd_idx = io_req.idx;
      end else if (cu_rd.valid) begin
         rd_idx = cu_rd.idx;
      end else begin
         rd_idx = '0;
      end
   end

   // A second I/O write cannot arrive before the slot drains
   a_pend_free : assert property (
      @(posedge clk) disable iff (!rst_n)
      io_req.wr |-> !pend_q.valid
   );

endmodule

// File: source/mbu_cu_decode.sv
// Control-unit decode of the microcode read and write address fields
// Combinational with no state, every output follows its inputs in the same cycle
// read_mbp is only honoured while t34 is low
// nir_idx low selects the index from ir, high selects {0, waddr[1:0]}
`timescale 1ns/1ps

module mbu_cu_decode (
   input  logic [4:0]         raddr,
   input  logic [4:0]         waddr,
   input  logic               t34,
   input  logic               nir_idx,
   input  mbu_pkg::mbu_idx_t  ir,
   input  mbu_pkg::mbu_byte_t ibus_in,
   output mbu_pkg::mbu_wr_req_t cu_wr,
   output mbu_pkg::mbu_rd_sel_t cu_rd,
   output logic               nwar
);

   ////////////////////
   // Address decode
   ////////////////////

   logic read_mbp;
   logic write_mbp;
   logic war;
   mbu_pkg::mbu_idx_t war_idx;

   // Both 01100 and 01101 put the bank pointer on the internal bus
   assign read_mbp = (raddr[4:1] == mbu_pkg::MBU_RADDR_MBP) && !t34;

   // Symmetric to the read side, both write_mbp codes load MB0
   assign write_mbp = (waddr[4:1] == mbu_pkg::MBU_WADDR_MBP);

   // Any write to the address register (001xx) uses an extended address
   assign war = (waddr[4:2] == mbu_pkg::MBU_WADDR_WAR);

   // The address register output is active low
   assign nwar = !war;

   ////////////////////
   // Index selection
   ////////////////////

   // Auto-indexed modes take the register from the instruction
   // Otherwise the low waddr bits name MB0 to MB3
   always_comb begin
      if (!nir_idx) begin
         war_idx = ir;
      end else begin
         war_idx = {1'b0, waddr[1:0]};
      end
   end

   ////////////////////
   // Requests
   ////////////////////

   // write_mbp always targets MB0 with the value on the internal bus
   always_comb begin
      cu_wr.valid = write_mbp;
      cu_wr.idx   = '0;
      cu_wr.data  = ibus_in;
   end

   // read_mbp wins over an indexed access in the same microinstruction
   // The two codes come from different fields, so both can be active
   always_comb begin
      cu_rd.valid = read_mbp || war;
      cu_rd.mbp   = read_mbp;
      if (read_mbp) begin
         cu_rd.idx = '0;
      end else begin
         cu_rd.idx = war_idx;
      end
   end

endmodule

// File: source/mbu_io_decode.sv
// I/O port decode for the IN and OUT instructions of the CPU
// IO_BASE must be a multiple of 8 below 8'h80, the low three bits are ignored
// Strobes nr and nw are single-cycle and active low with at least one idle cycle between
// Purely combinational, clk and rst_n only clock the protocol checks
`timescale 1ns/1ps

module mbu_io_decode #(
   parameter logic [7:0] IO_BASE = 8'h08
) (
   input  logic               clk,
   input  logic               rst_n,
   input  mbu_pkg::mbu_byte_t ab,
   input  logic               nsysdev,
   input  logic               nr,
   input  logic               nw,
   input  mbu_pkg::mbu_byte_t db_in,
   output mbu_pkg::mbu_io_req_t io_req,
   output logic               io_hit
);

   ////////////////////
   // Address match
   ////////////////////

   // The unit owns eight consecutive I/O addresses starting at IO_BASE
   logic addr_match;

   // Only system device space counts, memory cycles leave nsysdev high
   assign addr_match = !nsysdev && (ab[7:3] == IO_BASE[7:3]);

   ////////////////////
   // Request forming
   ////////////////////

   always_comb begin
      io_req.rd   = addr_match && !nr;
      io_req.wr   = addr_match && !nw;
      // The low address bits pick MB0 to MB7 directly
      io_req.idx  = ab[2:0];
      io_req.data = db_in;
   end

   // Any access in range enables the unit, IN as well as OUT
   assign io_hit = io_req.rd || io_req.wr;

   ////////////////////
   // Protocol checks
   ////////////////////

   // The bus master never reads and writes in the same cycle
   a_no_rd_wr_overlap : assert property (
      @(posedge clk) disable iff (!rst_n)
      !(!nr && !nw)
   );

   // Strobes last one cycle and are followed by an idle cycle
   // The arbiter relies on this to never meet two I/O writes back to back
   a_strobe_spacing : assert property (
      @(posedge clk) disable iff (!rst_n)
      (!nr || !nw) |=> (nr && nw)
   );

endmodule

// File: source/mbu_pkg.sv
// Shared widths, microcode address codes and request structs of the memory bank unit
// Struct field order sets the packed bit layout seen on every port
// All codes assume the 5-bit microcode read and write address fields of the CPU
package mbu_pkg;

   ////////////////////
   // Basic types
   ////////////////////

   // Index of one of the eight bank registers
   typedef logic [2:0] mbu_idx_t;

   // One data byte as carried on the internal bus and the system data bus
   typedef logic [7:0] mbu_byte_t;

   // MB0 to MB7, where MB0 is the memory bank pointer
   localparam int MBU_NREGS = 8;

   ////////////////////
   // Microcode codes
   ////////////////////

   // Upper four bits of read_mbp, the lowest raddr bit is a don't care (0110x)
   localparam logic [3:0] MBU_RADDR_MBP = 4'b0110;

   // Upper four bits of write_mbp, again decoded partially (0110x)
   localparam logic [3:0] MBU_WADDR_MBP = 4'b0110;

   // waddr[4:2] of an indexed access, the same decode drives nwar (001xx)
   localparam logic [2:0] MBU_WADDR_WAR = 3'b001;

   ////////////////////
   // Request structs
   ////////////////////

   // One write to the register file, 12 bits
   typedef struct packed {
      logic      valid;
      mbu_idx_t  idx;
      mbu_byte_t data;
   } mbu_wr_req_t;

   // Read select from the control unit, 5 bits
   // mbp marks read_mbp, otherwise valid alone marks an indexed access
   typedef struct packed {
      logic     valid;
      logic     mbp;
      mbu_idx_t idx;
   } mbu_rd_sel_t;

   // Decoded I/O access, 13 bits, rd and wr are never set together
   typedef struct packed {
      logic      rd;
      logic      wr;
      mbu_idx_t  idx;
      mbu_byte_t data;
   } mbu_io_req_t;

endpackage
